// File: common/kx_defines.svh
/*
 * Widths, counts and table depth for the match-action key extractor.
 * Include in any file that sizes a PHV field, a key or a tenant table.
 */
`ifndef KX_DEFINES_SVH
`define KX_DEFINES_SVH

// containers per size class
`define KX_NUM_CONT   8
`define KX_W_6B       48
`define KX_W_4B       32
`define KX_W_2B       16

// one compare opcode per pipeline stage
`define KX_NUM_STAGES 5
`define KX_OP_W       20
`define KX_MD_W       256

// tenant tables
`define KX_TBL_DEPTH  16
`define KX_IDX_W      4

// 2x6B + 2x4B + 2x2B + one compare bit per stage
`define KX_KEY_LEN    197
// six 3-bit container indices, first 6B field in the top bits
`define KX_OFF_LEN    18

// tenant index sits in the VLAN bits of the metadata
`define KX_TEN_LSB    133

`endif

// File: common/kx_pkg.sv
/*
 * Types shared by the key extractor: field vectors, the PHV layout,
 * the table-write request and the FSM and compare encodings.
 */
`include "kx_defines.svh"

package kx_pkg;

    typedef logic [`KX_W_6B-1:0]     cont_6b_t;
    typedef logic [`KX_W_4B-1:0]     cont_4b_t;
    typedef logic [`KX_W_2B-1:0]     cont_2b_t;
    typedef logic [`KX_OP_W-1:0]     op_t;
    typedef logic [`KX_KEY_LEN-1:0]  key_t;
    typedef logic [`KX_OFF_LEN-1:0]  key_off_t;
    typedef logic [`KX_IDX_W-1:0]    tbl_idx_t;
    typedef logic [7:0]              cmp_arg_t;

    // 1124 bits, container 7 of each class in the upper bits,
    // opcode 0 above opcode 4
    typedef struct packed {
        cont_6b_t [`KX_NUM_CONT-1:0]   c6;
        cont_4b_t [`KX_NUM_CONT-1:0]   c4;
        cont_2b_t [`KX_NUM_CONT-1:0]   c2;
        op_t      [0:`KX_NUM_STAGES-1] op;
        logic     [`KX_MD_W-1:0]       md;
    } phv_t;

    // table select values
    localparam logic TBL_SEL_OFF  = 1'b0;
    localparam logic TBL_SEL_MASK = 1'b1;

    // single-beat write into one of the two tenant tables
    typedef struct packed {
        logic     valid;
        logic     sel;
        tbl_idx_t idx;
        // offset table takes the low bits only
        key_t     data;
    } cfg_req_t;

    typedef enum logic [2:0] {
        IDLE,
        OPERANDS,
        TABLE_WAIT,
        EMIT,
        HOLD
    } kx_state_t;

    // opcode bits 19:18
    typedef enum logic [1:0] {
        GT     = 2'd0,
        GE     = 2'd1,
        EQ     = 2'd2,
        ALWAYS = 2'd3
    } cmp_kind_t;

endpackage

// File: hw/key_extract/tenant_table.sv
/*
 * Per-tenant lookup table, 16 entries of WIDTH bits.
 * One write port and a read port that returns data one cycle after its address.
 */
`include "kx_defines.svh"

module tenant_table #(
    parameter int WIDTH = 18
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  kx_pkg::tbl_idx_t wr_idx,
    input  logic [WIDTH-1:0] wr_data,
    input  kx_pkg::tbl_idx_t rd_idx,
    output logic [WIDTH-1:0] rd_data
);

    logic [WIDTH-1:0] mem [`KX_TBL_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `KX_TBL_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr_en) begin
                mem[wr_idx] <= wr_data;
            end
            // old contents on a same-cycle write to the read entry
            rd_data <= mem[rd_idx];
        end
    end

endmodule

// File: hw/key_extract/cmp_unit.sv
/*
 * Comparator of this stage's opcode. Resolves both operands from the
 * captured PHV, registers them on op_capture and compares them unsigned.
 */
module cmp_unit #(
    parameter int STAGE_ID = 0
) (
    input  logic         clk,
    input  logic         rst_n,
    input  kx_pkg::phv_t phv_q,
    input  logic         op_capture,
    output logic         cmp_bit
);
    import kx_pkg::*;

    op_t      stage_op;
    cmp_arg_t arg1;
    cmp_arg_t arg2;
    cmp_arg_t arg1_q;
    cmp_arg_t arg2_q;

    // immediate, or low byte of a container (size 3 gives zero)
    function automatic cmp_arg_t pick_arg(
        input phv_t       p,
        input logic       imm_sel,
        input cmp_arg_t   imm,
        input logic [1:0] size,
        input logic [2:0] idx
    );
        cmp_arg_t arg;
        if (imm_sel) begin
            arg = imm;
        end else begin
            case (size)
                2'd2:    arg = p.c6[idx][7:0];
                2'd1:    arg = p.c4[idx][7:0];
                2'd0:    arg = p.c2[idx][7:0];
                default: arg = '0;
            endcase
        end
        return arg;
    endfunction

    assign stage_op = phv_q.op[STAGE_ID];

    assign arg1 = pick_arg(phv_q, stage_op[17], stage_op[16:9], stage_op[13:12],
                           stage_op[11:9]);
    assign arg2 = pick_arg(phv_q, stage_op[8], stage_op[7:0], stage_op[4:3],
                           stage_op[2:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arg1_q <= '0;
            arg2_q <= '0;
        end else if (op_capture) begin
            arg1_q <= arg1;
            arg2_q <= arg2;
        end
    end

    // opcode stays put in phv_q until the next accept
    always_comb begin
        case (cmp_kind_t'(stage_op[19:18]))
            GT:      cmp_bit = (arg1_q >  arg2_q);
            GE:      cmp_bit = (arg1_q >= arg2_q);
            EQ:      cmp_bit = (arg1_q == arg2_q);
            default: cmp_bit = 1'b1;
        endcase
    end

endmodule

// File: hw/key_extract/key_assembler.sv
/*
 * Builds the raw key from six containers picked by the tenant's offset
 * entry, 6B 6B 4B 4B 2B 2B from the top, plus this stage's compare bit.
 */
`include "kx_defines.svh"

module key_assembler #(
    parameter int STAGE_ID = 0
) (
    input  kx_pkg::phv_t     phv_q,
    input  kx_pkg::key_off_t key_off,
    input  logic             cmp_bit,
    output kx_pkg::key_t     key_raw
);

    logic [2:0] sel_6b_hi;
    logic [2:0] sel_6b_lo;
    logic [2:0] sel_4b_hi;
    logic [2:0] sel_4b_lo;
    logic [2:0] sel_2b_hi;
    logic [2:0] sel_2b_lo;

    // offset entry fields, first key field in the top bits
    assign sel_6b_hi = key_off[`KX_OFF_LEN-1  -: 3];
    assign sel_6b_lo = key_off[`KX_OFF_LEN-4  -: 3];
    assign sel_4b_hi = key_off[`KX_OFF_LEN-7  -: 3];
    assign sel_4b_lo = key_off[`KX_OFF_LEN-10 -: 3];
    assign sel_2b_hi = key_off[`KX_OFF_LEN-13 -: 3];
    assign sel_2b_lo = key_off[`KX_OFF_LEN-16 -: 3];

    always_comb begin
        key_raw = {phv_q.c6[sel_6b_hi],
                   phv_q.c6[sel_6b_lo],
                   phv_q.c4[sel_4b_hi],
                   phv_q.c4[sel_4b_lo],
                   phv_q.c2[sel_2b_hi],
                   phv_q.c2[sel_2b_lo],
                   {`KX_NUM_STAGES{1'b0}}};
        // stage 0 owns bit 4, stage 4 owns bit 0
        key_raw[`KX_NUM_STAGES-1-STAGE_ID] = cmp_bit;
    end

endmodule

// File: hw/key_extract/kx_ctrl.sv
/*
 * Sequencer of the key extractor. Captures one PHV at a time, waits for
 * the table reads and the operand registers, then loads the outputs and
 * pulses valid once the downstream stage gives permission.
 */
`include "kx_defines.svh"

module kx_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  kx_pkg::phv_t     phv_in,
    input  logic             phv_valid_in,
    input  logic             ready_in,
    input  kx_pkg::key_t     key_raw,
    input  kx_pkg::key_t     mask_entry,
    output logic             ready_out,
    output kx_pkg::phv_t     phv_q,
    output kx_pkg::tbl_idx_t tenant,
    output logic             op_capture,
    output kx_pkg::phv_t     phv_out,
    output logic             phv_valid_out,
    output kx_pkg::key_t     key_out_masked,
    output logic             key_valid_out,
    output kx_pkg::key_t     key_mask_out
);
    import kx_pkg::*;

    kx_state_t state;
    kx_state_t state_nxt;
    logic      accept;
    logic      load_out;
    logic      release_out;
    logic      out_valid;

    assign accept      = (state == IDLE) && phv_valid_in && ready_out;
    assign load_out    = (state == EMIT);
    assign release_out = ((state == EMIT) || (state == HOLD)) && ready_in;

    // operands are sampled on the edge that leaves OPERANDS
    assign op_capture = (state == OPERANDS);

    // table address follows the captured PHV, stable until the next accept
    assign tenant = phv_q.md[`KX_TEN_LSB +: `KX_IDX_W];

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = OPERANDS;
                end
            end
            OPERANDS: begin
                state_nxt = TABLE_WAIT;
            end
            TABLE_WAIT: begin
                state_nxt = EMIT;
            end
            EMIT: begin
                state_nxt = ready_in ? IDLE : HOLD;
            end
            HOLD: begin
                if (ready_in) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            ready_out <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            out_valid <= release_out;
            if (accept) begin
                ready_out <= 1'b0;
            end else if (release_out) begin
                ready_out <= 1'b1;
            end
        end
    end

    // captured PHV
    always_ff @(posedge clk) begin
        if (accept) begin
            phv_q <= phv_in;
        end
    end

    // result registers, loaded in EMIT and held through HOLD
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_out        <= '0;
            key_mask_out   <= '0;
            key_out_masked <= '0;
        end else if (load_out) begin
            phv_out        <= phv_q;
            key_mask_out   <= mask_entry;
            key_out_masked <= key_raw | mask_entry;
        end
    end

    // both valids come from the same flop
    assign phv_valid_out = out_valid;
    assign key_valid_out = out_valid;

endmodule

// File: hw/key_extract/key_extract.sv
/*
 * Key extractor of one match-action stage. Captures a PHV, looks up the
 * tenant's offset and mask entries and emits the PHV with a masked key.
 */
`include "kx_defines.svh"

module key_extract #(
    parameter int STAGE_ID = 0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  kx_pkg::phv_t     phv_in,
    input  logic             phv_valid_in,
    output logic             ready_out,
    output kx_pkg::phv_t     phv_out,
    output logic             phv_valid_out,
    output kx_pkg::key_t     key_out_masked,
    output logic             key_valid_out,
    output kx_pkg::key_t     key_mask_out,
    input  logic             ready_in,
    input  kx_pkg::cfg_req_t cfg
);
    import kx_pkg::*;

    phv_t     phv_q;
    tbl_idx_t tenant;
    logic     op_capture;
    key_off_t key_off;
    key_t     mask_entry;
    key_t     key_raw;
    logic     cmp_bit;
    logic     off_wr_en;
    logic     mask_wr_en;

    assign off_wr_en  = cfg.valid && (cfg.sel == TBL_SEL_OFF);
    assign mask_wr_en = cfg.valid && (cfg.sel == TBL_SEL_MASK);

    kx_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_in         (phv_in),
        .phv_valid_in   (phv_valid_in),
        .ready_in       (ready_in),
        .key_raw        (key_raw),
        .mask_entry     (mask_entry),
        .ready_out      (ready_out),
        .phv_q          (phv_q),
        .tenant         (tenant),
        .op_capture     (op_capture),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out_masked (key_out_masked),
        .key_valid_out  (key_valid_out),
        .key_mask_out   (key_mask_out)
    );

    tenant_table #(.WIDTH(`KX_OFF_LEN)) offset_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (off_wr_en),
        .wr_idx  (cfg.idx),
        .wr_data (cfg.data[`KX_OFF_LEN-1:0]),
        .rd_idx  (tenant),
        .rd_data (key_off)
    );

    tenant_table #(.WIDTH(`KX_KEY_LEN)) mask_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (mask_wr_en),
        .wr_idx  (cfg.idx),
        .wr_data (cfg.data),
        .rd_idx  (tenant),
        .rd_data (mask_entry)
    );

    cmp_unit #(.STAGE_ID(STAGE_ID)) u_cmp (
        .clk        (clk),
        .rst_n      (rst_n),
        .phv_q      (phv_q),
        .op_capture (op_capture),
        .cmp_bit    (cmp_bit)
    );

    key_assembler #(.STAGE_ID(STAGE_ID)) u_asm (
        .phv_q   (phv_q),
        .key_off (key_off),
        .cmp_bit (cmp_bit),
        .key_raw (key_raw)
    );

endmodule

// File: tests/key_extract_assert.sv
/*
 * Handshake assertions for the key extractor, bound into every
 * key_extract instance from the bottom of this file.
 */
module key_extract_assert (
    input logic clk,
    input logic rst_n,
    input logic phv_valid_in,
    input logic ready_out,
    input logic phv_valid_out,
    input logic key_valid_out
);
    timeunit 1ns;
    timeprecision 1ps;

    logic in_flight;

    // set on accept, cleared when the result leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (phv_valid_in && ready_out) begin
            in_flight <= 1'b1;
        end else if (phv_valid_out) begin
            in_flight <= 1'b0;
        end
    end

    valids_equal: assert property (@(posedge clk) disable iff (!rst_n)
        phv_valid_out == key_valid_out)
        else $error("phv_valid_out and key_valid_out differ");

    valid_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        phv_valid_out |=> !phv_valid_out)
        else $error("valid stayed high for more than one cycle");

    ready_drops_on_accept: assert property (@(posedge clk) disable iff (!rst_n)
        (phv_valid_in && ready_out) |=> !ready_out)
        else $error("ready_out still high after an accept");

    ready_low_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        (in_flight && !phv_valid_out) |-> !ready_out)
        else $error("ready_out high while a PHV is in flight");

endmodule

bind key_extract key_extract_assert u_handshake_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .phv_valid_in  (phv_valid_in),
    .ready_out     (ready_out),
    .phv_valid_out (phv_valid_out),
    .key_valid_out (key_valid_out)
);

// File: tests/tb_key_extract.sv
/*
 * Directed testbench for the key extractor at stage 2. Programs the tenant
 * tables, sends PHVs and checks every result against a reference model.
 */
`include "kx_defines.svh"

module tb_key_extract;
    timeunit 1ns;
    timeprecision 1ps;
    import kx_pkg::*;

    localparam int STAGE = 2;
    localparam int CW = $bits(phv_t);
    localparam int MAX_WAIT = 40;
    // about six times the cycles the test sequence needs
    localparam int MAX_CYCLES = 3000;

    logic        clk;
    logic        rst_n;
    phv_t        phv_in;
    logic        phv_valid_in;
    logic        ready_out;
    phv_t        phv_out;
    logic        phv_valid_out;
    key_t        key_out_masked;
    logic        key_valid_out;
    key_t        key_mask_out;
    logic        ready_in;
    cfg_req_t    cfg;

    key_off_t    off_model [`KX_TBL_DEPTH];
    key_t        mask_model [`KX_TBL_DEPTH];
    logic [31:0] lcg_state;
    int          cycle_cnt;

    key_extract #(.STAGE_ID(STAGE)) i_key_extract (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_in         (phv_in),
        .phv_valid_in   (phv_valid_in),
        .ready_out      (ready_out),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out_masked (key_out_masked),
        .key_valid_out  (key_valid_out),
        .key_mask_out   (key_mask_out),
        .ready_in       (ready_in),
        .cfg            (cfg)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            stop_run($sformatf("timeout: the run did not finish in %0d cycles", MAX_CYCLES));
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [CW-1:0] got,
                             input logic [CW-1:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            stop_run($sformatf("mismatch on %s", name));
        end
    endtask

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic [31:0] rand32();
        return {rand16(), rand16()};
    endfunction

    function automatic phv_t random_phv();
        phv_t p;
        for (int i = 0; i < `KX_NUM_CONT; i++) begin
            p.c6[i] = {rand16(), rand16(), rand16()};
            p.c4[i] = rand32();
            p.c2[i] = rand16();
        end
        for (int i = 0; i < `KX_NUM_STAGES; i++) begin
            p.op[i] = op_t'(rand32());
        end
        for (int i = 0; i < 16; i++) begin
            p.md[i*16 +: 16] = rand16();
        end
        return p;
    endfunction

    // roughly one bit in eight set, so most key bits stay visible
    function automatic key_t sparse_mask();
        logic [207:0] w;
        for (int i = 0; i < 13; i++) begin
            w[i*16 +: 16] = rand16() & rand16() & rand16();
        end
        return key_t'(w);
    endfunction

    // operand field: imm flag, then value or {size, index} in the low bits
    function automatic cmp_arg_t operand_byte(input phv_t p, input logic [8:0] f);
        cmp_arg_t b;
        if (f[8]) begin
            b = f[7:0];
        end else begin
            case (f[4:3])
                2'd2:    b = p.c6[f[2:0]][7:0];
                2'd1:    b = p.c4[f[2:0]][7:0];
                2'd0:    b = p.c2[f[2:0]][7:0];
                default: b = 8'h00;
            endcase
        end
        return b;
    endfunction

    function automatic logic expected_cmp(input phv_t p);
        op_t      op;
        cmp_arg_t a;
        cmp_arg_t b;
        op = p.op[STAGE];
        a = operand_byte(p, op[17:9]);
        b = operand_byte(p, op[8:0]);
        case (op[19:18])
            2'd0:    return a > b;
            2'd1:    return a >= b;
            2'd2:    return a == b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic key_t expected_key(input phv_t p, input key_off_t off);
        key_t k;
        k = {p.c6[off[17:15]], p.c6[off[14:12]], p.c4[off[11:9]], p.c4[off[8:6]],
             p.c2[off[5:3]], p.c2[off[2:0]], 5'b00000};
        k[4 - STAGE] = expected_cmp(p);
        return k;
    endfunction

    function automatic logic [8:0] imm_operand(input cmp_arg_t v);
        return {1'b1, v};
    endfunction

    function automatic logic [8:0] cont_operand(input logic [1:0] size, input logic [2:0] idx);
        return {1'b0, 3'b000, size, idx};
    endfunction

    task automatic write_table(input logic sel, input tbl_idx_t idx, input key_t data);
        @(negedge clk);
        cfg.valid = 1'b1;
        cfg.sel   = sel;
        cfg.idx   = idx;
        cfg.data  = data;
        @(negedge clk);
        cfg.valid = 1'b0;
        if (sel == TBL_SEL_MASK) begin
            mask_model[idx] = data;
        end else begin
            off_model[idx] = key_off_t'(data);
        end
    endtask

    // one PHV through the DUT, ready_in held low for stall edges from E3 on
    task automatic run_packet(input phv_t p, input int stall, output key_t got_key);
        tbl_idx_t t;
        key_t     exp_key;
        int       n;
        t = p.md[`KX_TEN_LSB +: `KX_IDX_W];
        exp_key = expected_key(p, off_model[t]) | mask_model[t];
        @(negedge clk);
        check_val("ready_out before accept", CW'(ready_out), CW'(1'b1));
        phv_in = p;
        phv_valid_in = 1'b1;
        ready_in = (stall == 0);
        @(negedge clk);
        phv_valid_in = 1'b0;
        // the result must come from the captured copy
        phv_in = ~p;
        n = 0;
        while (phv_valid_out !== 1'b1) begin
            check_val("ready_out in flight", CW'(ready_out), CW'(1'b0));
            if (n >= MAX_WAIT) begin
                stop_run("no valid pulse appeared after the PHV was accepted");
            end
            if (n == 2 + stall) begin
                ready_in = 1'b1;
            end
            @(negedge clk);
            n++;
        end
        check_val("valid latency", CW'(n), CW'(3 + stall));
        check_val("key_valid_out", CW'(key_valid_out), CW'(1'b1));
        check_val("phv_out", CW'(phv_out), CW'(p));
        check_val("key_mask_out", CW'(key_mask_out), CW'(mask_model[t]));
        check_val("key_out_masked", CW'(key_out_masked), CW'(exp_key));
        got_key = key_out_masked;
        @(negedge clk);
        check_val("phv_valid_out after pulse", CW'(phv_valid_out), CW'(1'b0));
        check_val("phv_out held", CW'(phv_out), CW'(p));
        check_val("key_out_masked held", CW'(key_out_masked), CW'(exp_key));
    endtask

    task automatic test_reset();
        check_val("ready_out", CW'(ready_out), CW'(1'b1));
        check_val("phv_valid_out", CW'(phv_valid_out), CW'(1'b0));
        check_val("key_valid_out", CW'(key_valid_out), CW'(1'b0));
        check_val("phv_out", CW'(phv_out), '0);
        check_val("key_out_masked", CW'(key_out_masked), '0);
        check_val("key_mask_out", CW'(key_mask_out), '0);
    endtask

    task automatic test_tenants();
        phv_t p;
        key_t got;
        write_table(TBL_SEL_OFF, 4'd3, key_t'({3'd7, 3'd0, 3'd5, 3'd2, 3'd1, 3'd6}));
        write_table(TBL_SEL_OFF, 4'd9, key_t'({3'd2, 3'd2, 3'd0, 3'd7, 3'd4, 3'd3}));
        for (int i = 0; i < 4; i++) begin
            p = random_phv();
            p.md[`KX_TEN_LSB +: `KX_IDX_W] = (i % 2 == 0) ? 4'd3 : 4'd9;
            run_packet(p, 0, got);
        end
    endtask

    task automatic test_masking();
        phv_t p;
        key_t got;
        write_table(TBL_SEL_MASK, 4'd9, sparse_mask());
        for (int i = 0; i < 3; i++) begin
            p = random_phv();
            p.md[`KX_TEN_LSB +: `KX_IDX_W] = (i == 1) ? 4'd3 : 4'd9;
            run_packet(p, 0, got);
        end
    endtask

    // tenant 0 keeps a zero mask, so the compare bit shows through
    task automatic cmp_case(input cmp_kind_t kind, input logic [8:0] f1, input logic [8:0] f2,
                            input logic exp_bit);
        phv_t p;
        key_t got;
        p = random_phv();
        p.md[`KX_TEN_LSB +: `KX_IDX_W] = 4'd0;
        p.c6[1][7:0] = 8'h5a;
        p.c6[4][7:0] = 8'h80;
        p.c6[7][7:0] = 8'h11;
        p.c4[6][7:0] = 8'h5a;
        p.c4[2][7:0] = 8'h10;
        p.c2[3][7:0] = 8'h5b;
        p.c2[0][7:0] = 8'h7f;
        p.op[STAGE] = {kind, f1, f2};
        run_packet(p, 0, got);
        check_val("key compare bit", CW'(got[4 - STAGE]), CW'(exp_bit));
        check_val("key other low bits", CW'(got[4:0] & 5'b11011), CW'(5'b00000));
    endtask

    task automatic test_compare();
        cmp_case(GT, imm_operand(8'h05), imm_operand(8'h03), 1'b1);
        cmp_case(GT, imm_operand(8'h03), imm_operand(8'h03), 1'b0);
        cmp_case(GE, imm_operand(8'h03), imm_operand(8'h03), 1'b1);
        cmp_case(GE, imm_operand(8'h02), imm_operand(8'h03), 1'b0);
        cmp_case(EQ, cont_operand(2'd2, 3'd1), imm_operand(8'h5a), 1'b1);
        cmp_case(EQ, cont_operand(2'd1, 3'd6), cont_operand(2'd0, 3'd3), 1'b0);
        cmp_case(EQ, cont_operand(2'd1, 3'd6), cont_operand(2'd2, 3'd1), 1'b1);
        // 0x80 against 0x7f, unsigned
        cmp_case(GT, cont_operand(2'd2, 3'd4), cont_operand(2'd0, 3'd0), 1'b1);
        cmp_case(GE, cont_operand(2'd1, 3'd2), cont_operand(2'd2, 3'd7), 1'b0);
        cmp_case(GE, cont_operand(2'd2, 3'd7), cont_operand(2'd1, 3'd2), 1'b1);
        cmp_case(ALWAYS, imm_operand(8'h00), imm_operand(8'hff), 1'b1);
        cmp_case(EQ, cont_operand(2'd3, 3'd5), imm_operand(8'h00), 1'b1);
    endtask

    task automatic test_backpressure();
        phv_t p;
        key_t got;
        p = random_phv();
        p.md[`KX_TEN_LSB +: `KX_IDX_W] = 4'd9;
        run_packet(p, 7, got);
    endtask

    task automatic test_random();
        phv_t     p;
        key_t     got;
        tbl_idx_t t;
        int       stall;
        for (int i = 0; i < 30; i++) begin
            t = tbl_idx_t'(rand16());
            write_table(TBL_SEL_OFF, t, key_t'(key_off_t'(rand32())));
            write_table(TBL_SEL_MASK, t, sparse_mask());
            p = random_phv();
            // every third PHV keeps its own random tenant
            if (i % 3 != 0) begin
                p.md[`KX_TEN_LSB +: `KX_IDX_W] = t;
            end
            stall = int'(rand16() % 16'd4);
            run_packet(p, stall, got);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        phv_in = '0;
        phv_valid_in = 1'b0;
        ready_in = 1'b1;
        cfg = '0;
        lcg_state = 32'd22371;
        cycle_cnt = 0;
        for (int i = 0; i < `KX_TBL_DEPTH; i++) begin
            off_model[i] = '0;
            mask_model[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_tenants();
        test_masking();
        test_compare();
        test_backpressure();
        test_random();
        @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: build.f
+incdir+common
common/kx_pkg.sv
hw/key_extract/tenant_table.sv
hw/key_extract/cmp_unit.sv
hw/key_extract/key_assembler.sv
hw/key_extract/kx_ctrl.sv
hw/key_extract/key_extract.sv
tests/key_extract_assert.sv
tests/tb_key_extract.sv

// File: Makefile
# Verilator build and run of the key extractor testbench
VERILATOR  ?= verilator
TOP        := tb_key_extract
FILELIST   := build.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Done: no errors
HEADERS    := common/kx_defines.svh
SOURCES    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
